// File: design/serial_baud_gen.sv
// Baud tick generator
`default_nettype none
`include "serial_macros.svh"

module serial_baud_gen (
  input  wire        wb_clk_i,
  input  wire        wb_rst_i,
  input  wire [15:0] divisor_i,  // DLH:DLL
  output logic       tick8_o,    // Oversample tick
  output logic       tick1_o     // Bit tick
);

  localparam int SUB_W = $clog2(`SER_OVERSAMPLE);

  logic [15:0]      div_eff;
  logic [17:0]      reload;   // Clocks per tick8
  logic [17:0]      div_cnt;
  logic [SUB_W-1:0] sub_cnt;  // tick8 within a bit

  assign div_eff = (divisor_i == 16'd0) ? 16'd1 : divisor_i;  // 0 acts as 1
  assign reload  = 18'(div_eff) * 18'(`SER_CLKS_PER_DIV);

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      div_cnt <= '0;
      sub_cnt <= '0;
      tick8_o <= 1'b0;
      tick1_o <= 1'b0;
    end else if (div_cnt == 18'd0) begin
      div_cnt <= reload - 18'd1;  // Period is reload clocks
      sub_cnt <= sub_cnt + 1'b1;
      tick8_o <= 1'b1;
      tick1_o <= (sub_cnt == SUB_W'(`SER_OVERSAMPLE - 1));  // Every 8th
    end else begin
      div_cnt <= div_cnt - 18'd1;
      tick8_o <= 1'b0;
      tick1_o <= 1'b0;
    end
  end

  tick1_on_tick8: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    tick1_o |-> tick8_o)
    else $error("tick1 without tick8");

endmodule

`default_nettype wire

// File: design/serial_macros.svh
// Serial UART constants
`ifndef SERIAL_MACROS_SVH
`define SERIAL_MACROS_SVH

// --------------------
// Register reset values
`define SER_DLL_DEF       8'h60   // Divisor low byte
`define SER_DLH_DEF       8'h00   // Divisor high byte
`define SER_IER_DEF       4'h0    // All interrupts off
`define SER_LCR_DEF       8'h03   // 8 data bits
`define SER_MCR_DEF       5'h00   // Modem lines inactive

// --------------------
// Timing
`define SER_CLKS_PER_DIV  2       // Clocks per divisor unit, per 8x tick
`define SER_OVERSAMPLE    8       // Receiver ticks per bit
`define SER_RX_MID        4       // Sample point inside a bit
`define SER_DATA_BITS     8       // Fixed 8N1 frame

// --------------------
// Bit positions
`define LCR_DLAB_BIT      7       // Divisor latch access
`define MCR_DTR_BIT       0
`define MCR_RTS_BIT       1
`define MCR_OUT1_BIT      2
`define MCR_OUT2_BIT      3
`define MCR_LOOP_BIT      4       // Local loopback

`endif

// File: design/serial_pkg.sv
// Serial UART types
`default_nettype none

package serial_pkg;

  // One register byte
  typedef logic [7:0] byte_t;

  // Register map, 8250 order
  typedef enum logic [2:0] {
    RBR_THR = 3'd0,  // Receive buffer / transmit holding
    IER     = 3'd1,  // Interrupt enable
    IIR     = 3'd2,  // Interrupt identification
    LCR     = 3'd3,  // Line control
    MCR     = 3'd4,  // Modem control
    LSR     = 3'd5,  // Line status
    MSR     = 3'd6,  // Modem status
    SCR     = 3'd7   // Scratch, reads 0
  } reg_addr_e;

  // Interrupt ID field of IIR
  typedef enum logic [1:0] {
    ID_MODEM     = 2'b00,
    ID_THR_EMPTY = 2'b01,
    ID_RX_DATA   = 2'b10
  } int_id_e;

  typedef enum logic [1:0] {
    TX_IDLE, TX_START, TX_DATA, TX_STOP
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE, RX_START, RX_DATA, RX_STOP
  } rx_state_e;

endpackage

`default_nettype wire

// File: design/serial_reg_if.sv
// Register access link
`default_nettype none

interface serial_reg_if;

  logic                  wr_stb;  // One-cycle write command
  logic                  rd_stb;  // One-cycle read command
  serial_pkg::reg_addr_e addr;    // Register select
  serial_pkg::byte_t     wdata;   // Write byte, lane already picked
  serial_pkg::byte_t     rdata;   // Combinational read value

  // Bus port side
  modport bus (
    output wr_stb, rd_stb, addr, wdata,
    input  rdata
  );

  // Register block side
  modport regs (
    input  wr_stb, rd_stb, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: design/serial_regs.sv
// 8250 register block
`default_nettype none
`include "serial_macros.svh"

module serial_regs (
  input  wire               wb_clk_i,
  input  wire               wb_rst_i,
  serial_reg_if.regs        regs_i,
  input  wire               rx_valid_i,      // Frame received
  input  wire [7:0]         rx_data_i,
  input  wire               rx_frame_err_i,  // Valid with rx_valid_i
  input  wire               tx_busy_i,
  output logic              tx_start_o,      // Pulse, one cycle after THR write
  output serial_pkg::byte_t tx_data_o,       // THR contents
  output logic [15:0]       divisor_o,
  output logic              irq_o            // Driven onto wb_tgc_o
);

  logic [3:0]          ier;
  serial_pkg::byte_t   lcr;
  logic [4:0]          mcr;
  serial_pkg::byte_t   dll;
  serial_pkg::byte_t   dlh;
  serial_pkg::byte_t   rbr;          // Last received byte
  logic                dlab;
  logic                dr, ovr, fe, thre;
  logic                tx_busy_q;    // For falling edge
  logic                thr_wr, rbr_rd, lsr_rd;
  logic                rx_int, thr_int, modem_int, pending;
  logic [3:0]          modem;        // RLSD, RI, DSR, CTS
  serial_pkg::int_id_e int_id;
  serial_pkg::byte_t   iir, lsr, msr;

  assign dlab   = lcr[`LCR_DLAB_BIT];
  assign thr_wr = regs_i.wr_stb & (regs_i.addr == serial_pkg::RBR_THR) & ~dlab;
  assign rbr_rd = regs_i.rd_stb & (regs_i.addr == serial_pkg::RBR_THR) & ~dlab;
  assign lsr_rd = regs_i.rd_stb & (regs_i.addr == serial_pkg::LSR);

  // --------------------
  // Writable registers
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      ier <= `SER_IER_DEF;
      lcr <= `SER_LCR_DEF;  // Only DLAB acts, rest read back
      mcr <= `SER_MCR_DEF;
      dll <= `SER_DLL_DEF;
      dlh <= `SER_DLH_DEF;
    end else if (regs_i.wr_stb) begin
      case (regs_i.addr)
        serial_pkg::RBR_THR: if (dlab) dll <= regs_i.wdata;  // THR handled below
        serial_pkg::IER:     if (dlab) dlh <= regs_i.wdata; else ier <= regs_i.wdata[3:0];
        serial_pkg::LCR:     lcr <= regs_i.wdata;
        serial_pkg::MCR:     mcr <= regs_i.wdata[4:0];
        default: ;                                           // Read only or absent
      endcase
    end
  end

  // Data bytes
  always_ff @(posedge wb_clk_i) begin
    if (thr_wr) tx_data_o <= regs_i.wdata;
    if (rx_valid_i) rbr <= rx_data_i;
  end

  // --------------------
  // Line status and transmit kick
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      tx_start_o <= 1'b0;
      tx_busy_q  <= 1'b0;
      dr         <= 1'b0;
      ovr        <= 1'b0;
      fe         <= 1'b0;
      thre       <= 1'b1;  // Holding register starts empty
    end else begin
      tx_start_o <= thr_wr;
      tx_busy_q  <= tx_busy_i;
      if (rx_valid_i) dr <= 1'b1;  // New byte beats a read
      else if (rbr_rd) dr <= 1'b0;
      if (rx_valid_i && dr) ovr <= 1'b1;  // Previous byte never read
      else if (lsr_rd) ovr <= 1'b0;
      if (rx_valid_i && rx_frame_err_i) fe <= 1'b1;
      else if (lsr_rd) fe <= 1'b0;
      if (thr_wr) thre <= 1'b0;
      else if (tx_busy_q && !tx_busy_i) thre <= 1'b1;  // Frame finished
    end
  end

  // Bits 7..0: 0, TEMT, THRE, BI, FE, PE, OR, DR
  assign lsr = {1'b0, ~tx_busy_i, thre, 1'b0, fe, 1'b0, ovr, dr};

  // --------------------
  // Modem status, loopback only
  assign modem = mcr[`MCR_LOOP_BIT] ? {mcr[`MCR_OUT2_BIT], mcr[`MCR_OUT1_BIT],
                                       mcr[`MCR_DTR_BIT], mcr[`MCR_RTS_BIT]} : 4'h0;
  assign msr   = {modem, 4'h0};  // No delta bits

  // --------------------
  // Interrupts
  assign rx_int    = dr & ier[0];     // EDAI
  assign thr_int   = thre & ier[1];   // ETXH
  assign modem_int = (|modem) & ier[3];  // EMSI
  assign pending   = rx_int | thr_int | modem_int;
  assign irq_o     = pending;

  always_comb begin
    if (modem_int)      int_id = serial_pkg::ID_MODEM;  // Highest here
    else if (thr_int)   int_id = serial_pkg::ID_THR_EMPTY;
    else if (rx_int)    int_id = serial_pkg::ID_RX_DATA;
    else                int_id = serial_pkg::ID_MODEM;  // Code 00 when idle
  end

  assign iir = {5'b00000, int_id, ~pending};

  // --------------------
  // Read mux
  always_comb begin
    case (regs_i.addr)
      serial_pkg::RBR_THR: regs_i.rdata = dlab ? dll : rbr;
      serial_pkg::IER:     regs_i.rdata = dlab ? dlh : {4'h0, ier};
      serial_pkg::IIR:     regs_i.rdata = iir;
      serial_pkg::LCR:     regs_i.rdata = lcr;
      serial_pkg::MCR:     regs_i.rdata = {3'b000, mcr};
      serial_pkg::LSR:     regs_i.rdata = lsr;
      serial_pkg::MSR:     regs_i.rdata = msr;
      default:             regs_i.rdata = 8'h00;  // SCR
    endcase
  end

  assign divisor_o = {dlh, dll};

  // One kick per bus write even with stalled strobe
  tx_start_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    tx_start_o |=> !tx_start_o)
    else $error("tx_start high for two cycles");

endmodule

`default_nettype wire

// File: design/serial_rx.sv
// 8N1 receiver
`default_nettype none
`include "serial_macros.svh"

module serial_rx (
  input  wire                wb_clk_i,
  input  wire                wb_rst_i,
  input  wire                tick8_i,         // Oversample tick
  input  wire                rs232_rx_i,      // Asynchronous line
  output logic               rx_valid_o,      // Pulse at stop-bit sample
  output serial_pkg::byte_t  rx_data_o,
  output logic               rx_frame_err_o   // Low stop bit
);

  localparam int TICK_W = $clog2(`SER_OVERSAMPLE);
  localparam int BIT_W  = $clog2(`SER_DATA_BITS);

  logic                  rx_meta, rx_sync;  // Synchronizer
  serial_pkg::rx_state_e state;
  logic [TICK_W-1:0]     tick_cnt;          // Ticks since last sample
  logic [BIT_W-1:0]      bit_cnt;
  logic                  bit_point;         // Middle of the current bit
  serial_pkg::byte_t     shreg;

  // --------------------
  // Two-flop synchronizer
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rs232_rx_i;
      rx_sync <= rx_meta;
    end
  end

  assign bit_point = tick8_i && (tick_cnt == TICK_W'(`SER_OVERSAMPLE - 1));

  // --------------------
  // Frame sequencer
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state          <= serial_pkg::RX_IDLE;
      tick_cnt       <= '0;
      bit_cnt        <= '0;
      rx_valid_o     <= 1'b0;
      rx_frame_err_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (tick8_i) tick_cnt <= tick_cnt + 1'b1;  // Wraps every bit
      case (state)
        serial_pkg::RX_IDLE: begin
          if (tick8_i && !rx_sync) begin  // Possible start edge
            tick_cnt <= '0;
            state    <= serial_pkg::RX_START;
          end
        end
        serial_pkg::RX_START: begin
          if (tick8_i && tick_cnt == TICK_W'(`SER_RX_MID - 1)) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
            state    <= rx_sync ? serial_pkg::RX_IDLE : serial_pkg::RX_DATA;  // Glitch check
          end
        end
        serial_pkg::RX_DATA: begin
          if (bit_point) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == BIT_W'(`SER_DATA_BITS - 1)) state <= serial_pkg::RX_STOP;
          end
        end
        default: begin
          if (bit_point) begin
            rx_valid_o     <= 1'b1;
            rx_frame_err_o <= ~rx_sync;
            state          <= serial_pkg::RX_IDLE;
          end
        end
      endcase
    end
  end

  // Data shifts in LSB first
  always_ff @(posedge wb_clk_i) begin
    if (state == serial_pkg::RX_DATA && bit_point) shreg <= {rx_sync, shreg[7:1]};
  end

  assign rx_data_o = shreg;  // Stable from the pulse until the next frame

endmodule

`default_nettype wire

// File: design/serial_tx.sv
// 8N1 transmitter
`default_nettype none
`include "serial_macros.svh"

module serial_tx (
  input  wire                     wb_clk_i,
  input  wire                     wb_rst_i,
  input  wire                     tick1_i,     // One per bit time
  input  wire                     tx_start_i,  // Ignored while busy
  input  wire serial_pkg::byte_t  tx_data_i,
  output logic                    rs232_tx_o,
  output logic                    tx_busy_o
);

  localparam int BIT_W = $clog2(`SER_DATA_BITS + 1);

  serial_pkg::tx_state_e state;
  serial_pkg::byte_t     shreg;    // LSB goes out next
  logic [BIT_W-1:0]      bit_cnt;  // Data bits already sent
  logic                  data_done;

  assign data_done = (bit_cnt == BIT_W'(`SER_DATA_BITS));
  assign tx_busy_o = (state != serial_pkg::TX_IDLE);

  // --------------------
  // Frame sequencer
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state      <= serial_pkg::TX_IDLE;
      bit_cnt    <= '0;
      rs232_tx_o <= 1'b1;  // Line idles high
    end else begin
      case (state)
        serial_pkg::TX_IDLE: begin
          if (tx_start_i) state <= serial_pkg::TX_START;
        end
        serial_pkg::TX_START: begin  // Wait for bit boundary
          if (tick1_i) begin
            rs232_tx_o <= 1'b0;      // Start bit
            bit_cnt    <= '0;
            state      <= serial_pkg::TX_DATA;
          end
        end
        serial_pkg::TX_DATA: begin
          if (tick1_i) begin
            if (data_done) begin
              rs232_tx_o <= 1'b1;    // Stop bit
              state      <= serial_pkg::TX_STOP;
            end else begin
              rs232_tx_o <= shreg[0];
              bit_cnt    <= bit_cnt + 1'b1;
            end
          end
        end
        default: begin               // Stop bit on the line
          if (tick1_i) state <= serial_pkg::TX_IDLE;
        end
      endcase
    end
  end

  // Shift register
  always_ff @(posedge wb_clk_i) begin
    if (state == serial_pkg::TX_IDLE && tx_start_i) begin
      shreg <= tx_data_i;
    end else if (state == serial_pkg::TX_DATA && tick1_i && !data_done) begin
      shreg <= shreg >> 1;
    end
  end

endmodule

`default_nettype wire

// File: design/serial_uart.sv
// Wishbone 8250 UART top
`default_nettype none

module serial_uart (
  input  wire        wb_clk_i,
  input  wire        wb_rst_i,
  input  wire [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  input  wire [19:1] wb_adr_i,
  input  wire [ 1:0] wb_sel_i,
  input  wire        wb_we_i,
  input  wire        wb_cyc_i,
  input  wire        wb_stb_i,
  output logic       wb_ack_o,
  output logic       wb_tgc_o,    // Interrupt request
  output logic       rs232_tx_o,
  input  wire        rs232_rx_i
);

  logic              tick8, tick1;
  logic [15:0]       divisor;
  logic              tx_start, tx_busy;
  serial_pkg::byte_t tx_data;
  logic              rx_valid, rx_frame_err;
  serial_pkg::byte_t rx_data;

  serial_reg_if reg_bus ();  // Bus port to registers

  serial_wb_port i_wb_port (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .wb_dat_i (wb_dat_i),
    .wb_adr_i (wb_adr_i), .wb_sel_i (wb_sel_i), .wb_we_i  (wb_we_i),
    .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i), .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o), .bus_o    (reg_bus)
  );

  serial_regs i_regs (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .regs_i (reg_bus),
    .rx_valid_i (rx_valid), .rx_data_i (rx_data), .rx_frame_err_i (rx_frame_err),
    .tx_busy_i (tx_busy), .tx_start_o (tx_start), .tx_data_o (tx_data),
    .divisor_o (divisor), .irq_o (wb_tgc_o)
  );

  serial_baud_gen i_baud_gen (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .divisor_i (divisor),
    .tick8_o  (tick8),    .tick1_o  (tick1)
  );

  serial_tx i_tx (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .tick1_i (tick1),
    .tx_start_i (tx_start), .tx_data_i (tx_data),
    .rs232_tx_o (rs232_tx_o), .tx_busy_o (tx_busy)
  );

  serial_rx i_rx (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .tick8_i (tick8),
    .rs232_rx_i (rs232_rx_i), .rx_valid_o (rx_valid),
    .rx_data_o (rx_data), .rx_frame_err_o (rx_frame_err)
  );

endmodule

`default_nettype wire

// File: design/serial_wb_port.sv
// Wishbone slave port
`default_nettype none

module serial_wb_port (
  input  wire        wb_clk_i,
  input  wire        wb_rst_i,
  input  wire [15:0] wb_dat_i,   // Write data, both lanes
  input  wire [19:1] wb_adr_i,   // Only bits 2:1 decoded
  input  wire [ 1:0] wb_sel_i,   // Bit 1 is address bit 0, bit 0 picks lane
  input  wire        wb_we_i,
  input  wire        wb_cyc_i,
  input  wire        wb_stb_i,
  output logic [15:0] wb_dat_o,  // Read byte on one lane, zeros on other
  output logic        wb_ack_o,  // Registered, one cycle
  serial_reg_if.bus   bus_o
);

  logic              cmd;         // Command cycle
  logic              rd_lane_lo;  // Read byte goes to low lane
  serial_pkg::byte_t rd_byte;     // Latched read value

  // --------------------
  // Command decode
  assign cmd          = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // Once per access
  assign bus_o.wr_stb = cmd & wb_we_i;
  assign bus_o.rd_stb = cmd & ~wb_we_i;
  assign bus_o.addr   = serial_pkg::reg_addr_e'({wb_adr_i[2:1], wb_sel_i[1]});
  assign bus_o.wdata  = wb_sel_i[0] ? wb_dat_i[7:0] : wb_dat_i[15:8];

  // --------------------
  // Acknowledge
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= cmd;  // One cycle after command
    end
  end

  // Read data latch
  always_ff @(posedge wb_clk_i) begin
    if (bus_o.rd_stb) begin
      rd_byte    <= bus_o.rdata;  // Side effects hit at this same edge
      rd_lane_lo <= wb_sel_i[0];
    end
  end

  assign wb_dat_o = rd_lane_lo ? {8'h00, rd_byte} : {rd_byte, 8'h00};

  // Stalled strobe must not retrigger
  ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("wb_ack_o high for two cycles");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the serial_uart testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f serial_uart.f --top-module serial_uart_tb \
  --Mdir obj_dir -o sim_serial_uart
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_serial_uart)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "SIMULATION PASSED"; then
  exit 0
fi
exit 1

// File: serial_uart.f
+incdir+design
design/serial_pkg.sv
design/serial_reg_if.sv
design/serial_wb_port.sv
design/serial_regs.sv
design/serial_baud_gen.sv
design/serial_tx.sv
design/serial_rx.sv
design/serial_uart.sv
verif/serial_uart_tb.sv

// File: verif/serial_uart_tb.sv
// UART testbench
`default_nettype none

module serial_uart_tb;

  localparam int CLK_PERIOD  = 8;
  localparam int BIT_CLKS    = 16;                      // Divisor 1, 1 x 2 x 8
  localparam int FRAME_CLKS  = 10 * BIT_CLKS;
  localparam int WATCHDOG    = 40 * FRAME_CLKS + 2000;  // In cycles
  localparam int BUS_TIMEOUT = 16;

  logic        wb_clk_i   = 1'b0;
  logic        wb_rst_i   = 1'b1;
  logic [15:0] wb_dat_i   = 16'h0000;
  logic [19:1] wb_adr_i   = '0;
  logic [1:0]  wb_sel_i   = 2'b00;
  logic        wb_we_i    = 1'b0;
  logic        wb_cyc_i   = 1'b0;
  logic        wb_stb_i   = 1'b0;
  logic        rs232_rx_i = 1'b1;  // Line idles high
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;
  logic        wb_tgc_o;
  logic        rs232_tx_o;

  integer seed = 32'h80c50dc9;
  int     errors = 0;
  int     checks = 0;
  int     tests_passed = 0;
  int     tests_failed = 0;
  int     test_errors_at = 0;

  // Register model
  logic [3:0] m_ier;
  logic [7:0] m_lcr;
  logic [4:0] m_mcr;
  logic [7:0] m_dll, m_dlh, m_rbr;
  logic       m_dr, m_or, m_fe, m_thre, m_busy;

  // Read handed to the compare process
  event        read_done;
  logic [15:0] rd_got;
  logic [15:0] rd_exp;
  string       rd_what;

  serial_uart i_dut (
    .wb_clk_i (wb_clk_i), .wb_rst_i (wb_rst_i), .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o), .wb_adr_i (wb_adr_i), .wb_sel_i (wb_sel_i),
    .wb_we_i  (wb_we_i),  .wb_cyc_i (wb_cyc_i), .wb_stb_i (wb_stb_i),
    .wb_ack_o (wb_ack_o), .wb_tgc_o (wb_tgc_o), .rs232_tx_o (rs232_tx_o),
    .rs232_rx_i (rs232_rx_i)
  );

  always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

  // --------------------
  // Reference model
  function automatic logic [7:0] ref_reg(input serial_pkg::reg_addr_e addr);
    logic       dlab;
    logic [3:0] modem;
    logic       rx_int, thr_int, modem_int;
    logic [1:0] id;
    logic [7:0] v;
    dlab      = m_lcr[7];
    modem     = m_mcr[4] ? {m_mcr[3], m_mcr[2], m_mcr[0], m_mcr[1]} : 4'h0;  // Loopback
    rx_int    = m_dr & m_ier[0];
    thr_int   = m_thre & m_ier[1];
    modem_int = (|modem) & m_ier[3];
    if (modem_int) id = 2'b00;      // Modem first
    else if (thr_int) id = 2'b01;
    else if (rx_int) id = 2'b10;
    else id = 2'b00;
    case (addr)
      serial_pkg::RBR_THR: v = dlab ? m_dll : m_rbr;
      serial_pkg::IER:     v = dlab ? m_dlh : {4'h0, m_ier};
      serial_pkg::IIR:     v = {5'b00000, id, ~(rx_int | thr_int | modem_int)};
      serial_pkg::LCR:     v = m_lcr;
      serial_pkg::MCR:     v = {3'b000, m_mcr};
      serial_pkg::LSR:     v = {1'b0, ~m_busy, m_thre, 1'b0, m_fe, 1'b0, m_or, m_dr};
      serial_pkg::MSR:     v = {modem, 4'h0};
      default:             v = 8'h00;  // Scratch
    endcase
    return v;
  endfunction

  task automatic model_write(input serial_pkg::reg_addr_e addr, input logic [7:0] data);
    case (addr)
      serial_pkg::RBR_THR: begin
        if (m_lcr[7]) begin
          m_dll = data;
        end else begin
          m_thre = 1'b0;  // Frame starts
          m_busy = 1'b1;
        end
      end
      serial_pkg::IER: begin
        if (m_lcr[7]) m_dlh = data;
        else m_ier = data[3:0];
      end
      serial_pkg::LCR: m_lcr = data;
      serial_pkg::MCR: m_mcr = data[4:0];
      default: ;
    endcase
  endtask

  function automatic logic [7:0] rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[7:0];
  endfunction

  // --------------------
  // Bus access
  task automatic bus_access(input serial_pkg::reg_addr_e addr, input logic we,
                            input logic lane_lo, input logic [7:0] wdata,
                            output logic [15:0] rdata);
    logic [2:0] a;
    int         n;
    a        = addr;
    n        = 0;
    wb_adr_i = {17'h00000, a[2:1]};
    wb_sel_i = {a[0], lane_lo};
    wb_dat_i = lane_lo ? {~wdata, wdata} : {wdata, ~wdata};  // Junk on idle lane
    wb_we_i  = we;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    @(posedge wb_clk_i);
    #1;
    while (!wb_ack_o && n < BUS_TIMEOUT) begin
      @(posedge wb_clk_i);
      #1;
      n++;
    end
    if (!wb_ack_o) begin
      errors++;
      $display("Bus access to register %0d got no acknowledge at time %0t", a, $time);
    end
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic write_lane(input serial_pkg::reg_addr_e addr, input logic [7:0] data,
                            input logic lane_lo);
    logic [15:0] unused;
    bus_access(addr, 1'b1, lane_lo, data, unused);
    model_write(addr, data);
    @(posedge wb_clk_i);  // Ack drops
    #1;
  endtask

  task automatic write_reg(input serial_pkg::reg_addr_e addr, input logic [7:0] data);
    logic [2:0] a;
    a = addr;
    write_lane(addr, data, ~a[0]);  // Even registers on low lane
  endtask

  task automatic read_lane(input serial_pkg::reg_addr_e addr, input logic lane_lo,
                           input string what);
    logic [7:0]  exp;
    logic [15:0] got;
    exp = ref_reg(addr);
    bus_access(addr, 1'b0, lane_lo, 8'h00, got);
    rd_got  = got;
    rd_exp  = lane_lo ? {8'h00, exp} : {exp, 8'h00};
    rd_what = what;
    -> read_done;
    if (addr == serial_pkg::LSR) begin  // Read side effects
      m_or = 1'b0;
      m_fe = 1'b0;
    end
    if (addr == serial_pkg::RBR_THR && !m_lcr[7]) m_dr = 1'b0;
    @(posedge wb_clk_i);
    #1;
  endtask

  task automatic read_reg(input serial_pkg::reg_addr_e addr, input string what);
    logic [2:0] a;
    a = addr;
    read_lane(addr, ~a[0], what);
  endtask

  // Compare every read
  always @(read_done) begin
    checks++;
    assert (rd_got === rd_exp) else begin
      errors++;
      $display("CHECK FAILED at time %0t: read %s expected %h got %h",
               $time, rd_what, rd_exp, rd_got);
    end
  end

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("CHECK FAILED at time %0t: %s expected %b got %b", $time, what, exp, got);
    end
  endtask

  task automatic check_irq();
    logic [7:0] iir;
    iir = ref_reg(serial_pkg::IIR);
    check_bit("wb_tgc_o", wb_tgc_o, ~iir[0]);
  endtask

  // --------------------
  // Serial lines
  task automatic send_frame(input logic [7:0] data, input logic stop);
    logic [9:0] bits;
    int         i;
    bits = {stop, data, 1'b0};
    for (i = 0; i < 10; i++) begin
      rs232_rx_i = bits[0];  // LSB first
      bits       = bits >> 1;
      repeat (BIT_CLKS) @(posedge wb_clk_i);
      #1;
    end
    rs232_rx_i = 1'b1;
    repeat (BIT_CLKS) @(posedge wb_clk_i);  // Gap, stop sample is long past
    #1;
    m_rbr = data;
    if (m_dr) m_or = 1'b1;
    m_dr = 1'b1;
    if (!stop) m_fe = 1'b1;
  endtask

  task automatic check_tx_frame(input logic [7:0] data);
    logic [9:0] bits;
    int         n;
    int         i;
    bits = {1'b1, data, 1'b0};
    n    = 0;
    while (rs232_tx_o && n < 2 * FRAME_CLKS) begin  // Find start edge
      @(posedge wb_clk_i);
      #1;
      n++;
    end
    if (rs232_tx_o) begin
      errors++;
      $display("Transmitter never sent a start bit for byte %h", data);
    end else begin
      repeat (BIT_CLKS / 2) @(posedge wb_clk_i);  // Middle of start bit
      #1;
      for (i = 0; i < 10; i++) begin
        check_bit($sformatf("tx bit %0d of byte %h", i, data), rs232_tx_o, bits[0]);
        bits = bits >> 1;
        repeat (BIT_CLKS) @(posedge wb_clk_i);
        #1;
      end
    end
    m_thre = 1'b1;  // Stop bit over by now
    m_busy = 1'b0;
  endtask

  task automatic test_start();
    test_errors_at = errors;
  endtask

  task automatic test_end(input string name);
    if (errors == test_errors_at) begin
      tests_passed++;
      $display("Test %s: pass", name);
    end else begin
      tests_failed++;
      $display("Test %s: fail with %0d errors", name, errors - test_errors_at);
    end
  endtask

  // --------------------
  // Tests
  initial begin
    logic [7:0] b;
    logic [7:0] b2;
    int         k;
    m_ier  = 4'h0;  // Reset values
    m_lcr  = 8'h03;
    m_mcr  = 5'h00;
    m_dll  = 8'h60;
    m_dlh  = 8'h00;
    m_rbr  = 8'h00;
    m_dr   = 1'b0;
    m_or   = 1'b0;
    m_fe   = 1'b0;
    m_thre = 1'b1;
    m_busy = 1'b0;
    repeat (16) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    @(posedge wb_clk_i);
    #1;

    test_start();
    read_reg(serial_pkg::IER, "IER");
    read_reg(serial_pkg::LCR, "LCR");
    read_reg(serial_pkg::MCR, "MCR");
    read_reg(serial_pkg::IIR, "IIR");
    read_reg(serial_pkg::LSR, "LSR");
    read_reg(serial_pkg::SCR, "SCR");
    check_irq();
    write_reg(serial_pkg::LCR, 8'h83);  // DLAB on
    read_reg(serial_pkg::RBR_THR, "DLL");
    read_reg(serial_pkg::IER, "DLH");
    test_end("reset values");

    test_start();
    for (k = 0; k < 4; k++) begin  // Both lanes, both directions
      write_lane(serial_pkg::RBR_THR, rand_byte(), k[0]);
      write_lane(serial_pkg::IER, rand_byte(), ~k[0]);
      read_lane(serial_pkg::RBR_THR, ~k[0], "DLL");
      read_lane(serial_pkg::IER, k[0], "DLH");
    end
    write_reg(serial_pkg::RBR_THR, 8'h01);  // Divisor 1
    write_reg(serial_pkg::IER, 8'h00);
    read_reg(serial_pkg::RBR_THR, "DLL");
    write_reg(serial_pkg::LCR, 8'h03);
    read_lane(serial_pkg::IER, 1'b1, "IER low lane");
    read_lane(serial_pkg::IER, 1'b0, "IER high lane");
    test_end("divisor latch and lanes");

    test_start();
    for (k = 0; k < 4; k++) begin
      b = rand_byte();
      write_reg(serial_pkg::RBR_THR, b);
      check_tx_frame(b);
      read_reg(serial_pkg::LSR, "LSR after frame");
    end
    test_end("transmit");

    test_start();
    b = rand_byte();
    send_frame(b, 1'b1);
    read_reg(serial_pkg::LSR, "LSR data ready");
    read_reg(serial_pkg::RBR_THR, "RBR");
    b  = rand_byte();
    b2 = rand_byte();
    send_frame(b, 1'b1);
    send_frame(b2, 1'b1);  // Nobody read the first
    read_reg(serial_pkg::LSR, "LSR overrun");
    read_reg(serial_pkg::LSR, "LSR overrun cleared");
    read_reg(serial_pkg::RBR_THR, "RBR after overrun");
    b = rand_byte();
    send_frame(b, 1'b0);   // Low stop bit
    read_reg(serial_pkg::LSR, "LSR framing error");
    read_reg(serial_pkg::LSR, "LSR framing cleared");
    read_reg(serial_pkg::RBR_THR, "RBR after framing error");
    test_end("receive and errors");

    test_start();
    write_reg(serial_pkg::IER, 8'h01);  // EDAI
    check_irq();
    b = rand_byte();
    send_frame(b, 1'b1);
    check_irq();
    read_reg(serial_pkg::IIR, "IIR rx data");
    read_reg(serial_pkg::RBR_THR, "RBR");
    check_irq();
    read_reg(serial_pkg::IIR, "IIR after RBR read");
    write_reg(serial_pkg::IER, 8'h02);  // ETXH
    read_reg(serial_pkg::IIR, "IIR THR empty");
    b = rand_byte();
    write_reg(serial_pkg::RBR_THR, b);
    read_reg(serial_pkg::IIR, "IIR after THR write");
    check_irq();
    check_tx_frame(b);
    read_reg(serial_pkg::IIR, "IIR after frame");
    check_irq();
    write_reg(serial_pkg::IER, 8'h00);
    test_end("interrupts");

    test_start();
    write_reg(serial_pkg::MCR, 8'h11);  // LOOP and DTR
    read_reg(serial_pkg::MCR, "MCR");
    read_reg(serial_pkg::MSR, "MSR loopback");
    write_reg(serial_pkg::IER, 8'h08);  // EMSI
    read_reg(serial_pkg::IIR, "IIR modem");
    check_irq();
    write_reg(serial_pkg::MCR, 8'h00);
    read_reg(serial_pkg::IIR, "IIR modem cleared");
    check_irq();
    test_end("modem loopback");

    $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG * CLK_PERIOD);
    $display("Run timed out after %0d cycles", WATCHDOG);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire
